/* build.f */
source/lsu_pkg.sv
source/store_align.sv
source/load_extract.sv
source/data_bus_unit.sv
source/lsu_top.sv
dv/l1_mem_model.sv
dv/lsu_tb.sv

/* dv/l1_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

// L1 data port model, byte-strobed word memory with random handshake delays

module l1_mem_model
    import lsu_pkg::*;
(
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              req_valid_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic              req_write_i,
    input  logic [DATA_W-1:0] req_wdata_i,
    input  logic [STRB_W-1:0] req_strb_i,
    output logic              req_ready_o,
    output logic              rsp_valid_o,
    output logic [DATA_W-1:0] rsp_data_o,
    input  logic              rsp_ready_i,
    output int                req_count_o
);

    logic [DATA_W-1:0] mem [0:255];
    logic [7:0]        rd_index;
    logic              rd_pending;
    int                seed = 45;
    int                req_delay;
    int                rsp_delay;

    // Initial contents, a different word at every address
    function automatic logic [31:0] fill_word(input logic [31:0] idx);
        return (idx * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
    endfunction

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= fill_word(i);
            end
            req_ready_o <= 1'b0;
            rsp_valid_o <= 1'b0;
            rsp_data_o  <= '0;
            rd_pending  <= 1'b0;
            rd_index    <= '0;
            req_delay   <= 0;
            rsp_delay   <= 0;
            req_count_o <= 0;
        end else begin
            if (req_valid_i && req_ready_o) begin
                req_ready_o <= 1'b0;
                req_count_o <= req_count_o + 1;
                req_delay   <= $unsigned($random(seed)) % 4;
                if (req_write_i) begin
                    for (int b = 0; b < STRB_W; b++) begin
                        if (req_strb_i[b]) begin
                            mem[req_addr_i[9:2]][b*8 +: 8] <= req_wdata_i[b*8 +: 8];
                        end
                    end
                end else begin
                    rd_pending <= 1'b1;
                    rd_index   <= req_addr_i[9:2];
                    rsp_delay  <= $unsigned($random(seed)) % 4;
                end
            end else if (req_valid_i) begin
                if (req_delay == 0) begin
                    req_ready_o <= 1'b1;
                end else begin
                    req_delay <= req_delay - 1;
                end
            end

            // Read data after its own delay
            if (rd_pending && !rsp_valid_o) begin
                if (rsp_delay == 0) begin
                    rsp_valid_o <= 1'b1;
                    rsp_data_o  <= mem[rd_index];
                end else begin
                    rsp_delay <= rsp_delay - 1;
                end
            end
            if (rsp_valid_o && rsp_ready_i) begin
                rsp_valid_o <= 1'b0;
                rd_pending  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
;

    localparam int WATCHDOG_CYCLES = 300 * 12;

    logic              clk_i = 1'b0;
    logic              arst_n_i;
    logic              req_valid_i;
    logic [OP_W-1:0]   req_op_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic [DATA_W-1:0] req_wdata_i;
    logic              busy_o;
    logic              done_o;
    logic [DATA_W-1:0] rdata_o;
    logic              misaligned_o;
    logic              port_req_valid;
    logic [ADDR_W-1:0] port_req_addr;
    logic              port_req_write;
    logic [DATA_W-1:0] port_req_wdata;
    logic [STRB_W-1:0] port_req_strb;
    logic              port_req_ready;
    logic              port_rsp_valid;
    logic [DATA_W-1:0] port_rsp_data;
    logic              port_rsp_ready;
    int                req_count;

    logic [7:0]        shadow [0:1023];     // Byte view of the model memory
    logic [DATA_W-1:0] exp_data_q [$];
    logic              exp_mis_q [$];
    logic [DATA_W-1:0] held_rdata = '0;     // Result of the last completion
    logic              held_mis = 1'b0;
    logic [OP_W-1:0]   op_list [0:7];
    int                errors = 0;
    int                checks = 0;
    int                seed = 45;

    always #50 clk_i = ~clk_i;

    lsu_top u_dut (
        .clk_i (clk_i), .arst_n_i (arst_n_i),
        .req_valid_i (req_valid_i), .req_op_i (req_op_i),
        .req_addr_i (req_addr_i), .req_wdata_i (req_wdata_i),
        .busy_o (busy_o), .done_o (done_o), .rdata_o (rdata_o), .misaligned_o (misaligned_o),
        .port_req_valid_o (port_req_valid), .port_req_addr_o (port_req_addr),
        .port_req_write_o (port_req_write), .port_req_wdata_o (port_req_wdata),
        .port_req_strb_o (port_req_strb), .port_req_ready_i (port_req_ready),
        .port_rsp_valid_i (port_rsp_valid), .port_rsp_data_i (port_rsp_data),
        .port_rsp_ready_o (port_rsp_ready)
    );

    l1_mem_model u_mem (
        .clk_i (clk_i), .arst_n_i (arst_n_i),
        .req_valid_i (port_req_valid), .req_addr_i (port_req_addr),
        .req_write_i (port_req_write), .req_wdata_i (port_req_wdata),
        .req_strb_i (port_req_strb), .req_ready_o (port_req_ready),
        .rsp_valid_o (port_rsp_valid), .rsp_data_o (port_rsp_data),
        .rsp_ready_i (port_rsp_ready), .req_count_o (req_count)
    );

    // Expected {misaligned, rdata} from the access rules and the shadow bytes
    function automatic logic [32:0] expect_result(input logic [OP_W-1:0] op,
                                                  input logic [31:0] addr);
        logic [9:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        logic        mis;
        a   = addr[9:0];
        mis = (op[1:0] == SIZE_H) ? addr[0] : ((op[1:0] == SIZE_B) ? 1'b0 : (addr[1:0] != 2'b00));
        if (mis || op[OP_ST_BIT]) begin
            return {mis, 32'h0};
        end
        b = shadow[a];
        h = {shadow[a + 10'd1], shadow[a]};
        case (op[1:0])
            SIZE_B:  return {1'b0, op[OP_UNS_BIT] ? {24'h0, b} : {{24{b[7]}}, b}};
            SIZE_H:  return {1'b0, op[OP_UNS_BIT] ? {16'h0, h} : {{16{h[15]}}, h}};
            default: return {1'b0, shadow[a + 10'd3], shadow[a + 10'd2], h};
        endcase
    endfunction

    task automatic issue(input logic [OP_W-1:0] op, input logic [31:0] addr,
                         input logic [31:0] wdata);
        logic [32:0] res;
        logic [9:0]  a;
        @(posedge clk_i);
        #1;
        while (busy_o) begin
            @(posedge clk_i);
            #1;
        end
        res = expect_result(op, addr);
        exp_data_q.push_back(res[31:0]);
        exp_mis_q.push_back(res[32]);
        a = addr[9:0];
        if (op[OP_ST_BIT] && !res[32]) begin
            shadow[a] = wdata[7:0];
            if (op[1:0] != SIZE_B) shadow[a + 10'd1] = wdata[15:8];
            if (op[1:0] == SIZE_W) begin
                shadow[a + 10'd2] = wdata[23:16];
                shadow[a + 10'd3] = wdata[31:24];
            end
        end
        req_valid_i = 1'b1;
        req_op_i    = op;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
        // One cycle after the strobe, misaligned is done and aligned is busy on the port
        if ({busy_o, port_req_valid, done_o} !== {!res[32], !res[32], res[32]}) begin
            $display("FAIL busy_o,port_req_valid_o,done_o exp %h got %h",
                     {!res[32], !res[32], res[32]}, {busy_o, port_req_valid, done_o});
            errors++;
        end
        @(negedge clk_i);
        while (!done_o) @(negedge clk_i);
    endtask

    // Compare at every completion, and check the results hold in between
    always @(negedge clk_i) begin
        if (arst_n_i && done_o) begin
            checks++;
            if (busy_o !== 1'b0) begin
                $display("FAIL busy_o exp %h got %h", 1'b0, busy_o);
                errors++;
            end
            if (exp_data_q.size() == 0) begin
                $display("Completion seen with no request outstanding");
                errors++;
            end else begin
                if (rdata_o !== exp_data_q[0]) begin
                    $display("FAIL rdata_o exp %h got %h", exp_data_q[0], rdata_o);
                    errors++;
                end
                if (misaligned_o !== exp_mis_q[0]) begin
                    $display("FAIL misaligned_o exp %h got %h", exp_mis_q[0], misaligned_o);
                    errors++;
                end
                held_rdata = exp_data_q[0];
                held_mis   = exp_mis_q[0];
                void'(exp_data_q.pop_front());
                void'(exp_mis_q.pop_front());
            end
        end else if (arst_n_i) begin
            if (rdata_o !== held_rdata) begin
                $display("FAIL rdata_o exp %h got %h between completions", held_rdata, rdata_o);
                errors++;
            end
            if (misaligned_o !== held_mis) begin
                $display("FAIL misaligned_o exp %h got %h between completions",
                         held_mis, misaligned_o);
                errors++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("Timeout: the run did not finish in the allowed time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int        count_before;
        int        r;
        logic [31:0] w;
        op_list = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
        for (int i = 0; i < 256; i++) begin
            w = (i * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;   // Same fill as the model
            for (int b = 0; b < 4; b++) shadow[i*4 + b] = w[b*8 +: 8];
        end
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_op_i    = '0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        repeat (4) @(posedge clk_i);
        #1 arst_n_i = 1'b1;

        // Idle outputs after reset
        repeat (8) begin
            @(negedge clk_i);
            if ({busy_o, done_o, misaligned_o} !== 3'b000) begin
                $display("FAIL busy_o,done_o,misaligned_o exp %h got %h", 3'b000,
                         {busy_o, done_o, misaligned_o});
                errors++;
            end
            if ({port_req_valid, port_rsp_ready} !== 2'b00) begin
                $display("FAIL port_req_valid_o,port_rsp_ready_o exp %h got %h", 2'b00,
                         {port_req_valid, port_rsp_ready});
                errors++;
            end
            if (rdata_o !== 32'h0) begin
                $display("FAIL rdata_o exp %h got %h", 32'h0, rdata_o);
                errors++;
            end
        end

        for (int i = 0; i < 16; i++) issue(OP_SW, i * 4, $random(seed));
        for (int i = 0; i < 16; i++) issue(OP_LW, i * 4, 0);

        // Sub-word stores, then whole-word readback
        for (int off = 0; off < 4; off++) issue(OP_SB, 80 + off, 32'h0000_00C0 + off);
        issue(OP_LW, 80, 0);
        issue(OP_SH, 84, 32'h0000_BEEF);
        issue(OP_SH, 86, 32'h0000_1234);
        issue(OP_LW, 84, 0);

        // Sign and zero extension, top bit set and clear
        for (int off = 0; off < 4; off++) begin
            issue(OP_SB, 96 + off, 32'h0000_0085);
            issue(OP_LB, 96 + off, 0);
            issue(OP_LBU, 96 + off, 0);
            issue(OP_SB, 96 + off, 32'h0000_0071);
            issue(OP_LB, 96 + off, 0);
            issue(OP_LBU, 96 + off, 0);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue(OP_SH, 100 + off, 32'h0000_9A3C);
            issue(OP_LH, 100 + off, 0);
            issue(OP_LHU, 100 + off, 0);
            issue(OP_SH, 100 + off, 32'h0000_6A3C);
            issue(OP_LH, 100 + off, 0);
            issue(OP_LHU, 100 + off, 0);
        end

        // Misaligned accesses must not reach the port
        count_before = req_count;
        issue(OP_LH, 32'h41, 0);
        issue(OP_LHU, 32'h43, 0);
        issue(OP_SH, 32'h45, 32'hFFFF_FFFF);
        issue(OP_LW, 32'h42, 0);
        issue(OP_SW, 32'h49, 32'hFFFF_FFFF);
        if (req_count != count_before) begin
            $display("Misaligned access produced %0d port requests", req_count - count_before);
            errors++;
        end
        issue(OP_LW, 32'h44, 0);
        issue(OP_LW, 32'h48, 0);

        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            w = $random(seed);
            issue(op_list[$unsigned(r) % 8], {22'h0, w[9:0]}, $random(seed));
        end

        repeat (3) @(posedge clk_i);
        if (exp_data_q.size() != 0) begin
            $display("Requests left without completion");
            errors++;
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f build.f --top-module lsu_tb -o lsu_sim
output=$(./obj_dir/lsu_sim)
echo "$output"
echo "$output" | grep -q "TEST RESULT: PASS"

/* source/data_bus_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// Load/store controller between the core strobe and the L1 data port

module data_bus_unit
    import lsu_pkg::*;
(
    input  logic              clk_i,
    input  logic              arst_n_i,

    // Core request
    input  logic              req_valid_i,
    input  logic [OP_W-1:0]   req_op_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [DATA_W-1:0] req_wdata_i,

    // From store_align
    input  logic [STRB_W-1:0] strb_i,
    input  logic [DATA_W-1:0] lane_data_i,
    input  logic              misaligned_i,

    // From load_extract
    input  logic [DATA_W-1:0] value_i,

    // Request seen by both data paths
    output logic [OP_W-1:0]   op_o,
    output logic [ADDR_W-1:0] addr_o,

    // Core status
    output logic              busy_o,
    output logic              done_o,
    output logic [DATA_W-1:0] rdata_o,
    output logic              misaligned_o,

    // L1 port
    output logic              port_req_valid_o,
    output logic [ADDR_W-1:0] port_req_addr_o,
    output logic              port_req_write_o,
    output logic [DATA_W-1:0] port_req_wdata_o,
    output logic [STRB_W-1:0] port_req_strb_o,
    input  logic              port_req_ready_i,
    input  logic              port_rsp_valid_i,
    input  logic [DATA_W-1:0] port_rsp_data_i,
    output logic              port_rsp_ready_o
);

    logic [ST_W-1:0]   state_r,      state_ns;
    logic [OP_W-1:0]   op_r,         op_ns;
    logic [ADDR_W-1:0] addr_r,       addr_ns;
    logic              busy_r,       busy_ns;
    logic              done_r,       done_ns;
    logic [DATA_W-1:0] rdata_r,      rdata_ns;
    logic              misalign_r,   misalign_ns;
    logic              req_valid_r,  req_valid_ns;
    logic [ADDR_W-1:0] req_addr_r,   req_addr_ns;
    logic              req_write_r,  req_write_ns;
    logic [DATA_W-1:0] req_wdata_r,  req_wdata_ns;
    logic [STRB_W-1:0] req_strb_r,   req_strb_ns;
    logic              rsp_ready_r,  rsp_ready_ns;
    logic              accept;

    // Strobe is only legal while not busy
    assign accept = req_valid_i && !busy_r;

    // While free, the data paths look at the incoming request directly
    assign op_o   = busy_r ? op_r   : req_op_i;
    assign addr_o = busy_r ? addr_r : req_addr_i;

    always_comb begin
        state_ns     = state_r;
        op_ns        = op_r;
        addr_ns      = addr_r;
        busy_ns      = busy_r;
        done_ns      = 1'b0;                  // One-cycle pulse
        rdata_ns     = rdata_r;
        misalign_ns  = misalign_r;
        req_valid_ns = req_valid_r;
        req_addr_ns  = req_addr_r;
        req_write_ns = req_write_r;
        req_wdata_ns = req_wdata_r;
        req_strb_ns  = req_strb_r;
        rsp_ready_ns = rsp_ready_r;

        case (state_r)
            ST_IDLE, ST_DONE: begin
                if (accept) begin
                    op_ns   = req_op_i;
                    addr_ns = req_addr_i;
                    if (misaligned_i) begin
                        // Finish at once, nothing goes to the port
                        misalign_ns = 1'b1;
                        rdata_ns    = '0;
                        done_ns     = 1'b1;
                        state_ns    = ST_DONE;
                    end else begin
                        busy_ns      = 1'b1;
                        req_valid_ns = 1'b1;
                        req_addr_ns  = {req_addr_i[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
                        req_write_ns = req_op_i[OP_ST_BIT];
                        req_wdata_ns = lane_data_i;
                        req_strb_ns  = strb_i;
                        state_ns     = ST_REQ;
                    end
                end else begin
                    state_ns = ST_IDLE;
                end
            end
            ST_REQ: begin
                if (port_req_ready_i) begin
                    req_valid_ns = 1'b0;
                    if (req_write_r) begin
                        misalign_ns = 1'b0;
                        rdata_ns    = '0;
                        busy_ns     = 1'b0;   // Stores end on the request beat
                        done_ns     = 1'b1;
                        state_ns    = ST_DONE;
                    end else begin
                        rsp_ready_ns = 1'b1;
                        state_ns     = ST_WAIT;
                    end
                end
            end
            ST_WAIT: begin
                if (port_rsp_valid_i) begin
                    rsp_ready_ns = 1'b0;
                    misalign_ns  = 1'b0;
                    rdata_ns     = value_i;   // Already extended
                    busy_ns      = 1'b0;
                    done_ns      = 1'b1;
                    state_ns     = ST_DONE;
                end
            end
            default: state_ns = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_r     <= ST_IDLE;
            busy_r      <= 1'b0;
            done_r      <= 1'b0;
            rdata_r     <= '0;
            misalign_r  <= 1'b0;
            req_valid_r <= 1'b0;
            rsp_ready_r <= 1'b0;
        end else begin
            state_r     <= state_ns;
            busy_r      <= busy_ns;
            done_r      <= done_ns;
            rdata_r     <= rdata_ns;
            misalign_r  <= misalign_ns;
            req_valid_r <= req_valid_ns;
            rsp_ready_r <= rsp_ready_ns;
        end
    end

    // Request payload
    always_ff @(posedge clk_i) begin
        op_r        <= op_ns;
        addr_r      <= addr_ns;
        req_addr_r  <= req_addr_ns;
        req_write_r <= req_write_ns;
        req_wdata_r <= req_wdata_ns;
        req_strb_r  <= req_strb_ns;
    end

    assign busy_o           = busy_r;
    assign done_o           = done_r;
    assign rdata_o          = rdata_r;
    assign misaligned_o     = misalign_r;
    assign port_req_valid_o = req_valid_r;
    assign port_req_addr_o  = req_addr_r;
    assign port_req_write_o = req_write_r;
    assign port_req_wdata_o = req_wdata_r;
    assign port_req_strb_o  = req_strb_r;
    assign port_rsp_ready_o = rsp_ready_r;

endmodule

`default_nettype wire

/* source/load_extract.sv */
`timescale 1ns/1ps
`default_nettype none

// Picks the addressed bytes out of a read word and extends them

module load_extract
    import lsu_pkg::*;
(
    input  logic [OP_W-1:0]   op_i,
    input  logic [OFF_W-1:0]  offset_i,
    input  logic [DATA_W-1:0] word_i,
    output logic [DATA_W-1:0] value_o
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        is_unsigned;

    assign is_unsigned = op_i[OP_UNS_BIT];

    // Byte lane select
    always_comb begin
        case (offset_i)
            2'd0:    byte_sel = word_i[7:0];
            2'd1:    byte_sel = word_i[15:8];
            2'd2:    byte_sel = word_i[23:16];
            default: byte_sel = word_i[31:24];
        endcase
    end

    // Only even offsets reach here for halfwords
    assign half_sel = offset_i[1] ? word_i[31:16] : word_i[15:0];

    always_comb begin
        case (op_i[1:0])
            SIZE_B: begin
                if (is_unsigned) begin
                    value_o = {{(DATA_W-8){1'b0}}, byte_sel};
                end else begin
                    value_o = {{(DATA_W-8){byte_sel[7]}}, byte_sel};
                end
            end
            SIZE_H: begin
                if (is_unsigned) begin
                    value_o = {{(DATA_W-16){1'b0}}, half_sel};
                end else begin
                    value_o = {{(DATA_W-16){half_sel[15]}}, half_sel};
                end
            end
            default: value_o = word_i;        // Word, or reserved size
        endcase
    end

endmodule

`default_nettype wire

/* source/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int OFF_W  = $clog2(STRB_W);    // Byte offset within a word

    // Access kind layout: {store, unsigned, size[1:0]}
    localparam int OP_W       = 4;
    localparam int OP_ST_BIT  = 3;
    localparam int OP_UNS_BIT = 2;

    // Access sizes in the low two bits of the op code
    localparam logic [1:0] SIZE_B = 2'd0;
    localparam logic [1:0] SIZE_H = 2'd1;
    localparam logic [1:0] SIZE_W = 2'd2;

    // Loads
    localparam logic [OP_W-1:0] OP_LB  = {1'b0, 1'b0, SIZE_B};
    localparam logic [OP_W-1:0] OP_LH  = {1'b0, 1'b0, SIZE_H};
    localparam logic [OP_W-1:0] OP_LW  = {1'b0, 1'b0, SIZE_W};
    localparam logic [OP_W-1:0] OP_LBU = {1'b0, 1'b1, SIZE_B};
    localparam logic [OP_W-1:0] OP_LHU = {1'b0, 1'b1, SIZE_H};

    // Stores
    localparam logic [OP_W-1:0] OP_SB  = {1'b1, 1'b0, SIZE_B};
    localparam logic [OP_W-1:0] OP_SH  = {1'b1, 1'b0, SIZE_H};
    localparam logic [OP_W-1:0] OP_SW  = {1'b1, 1'b0, SIZE_W};

    // Controller FSM encoding
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
    localparam logic [ST_W-1:0] ST_REQ  = 2'd1;   // Request held on the L1 port
    localparam logic [ST_W-1:0] ST_WAIT = 2'd2;   // Load waiting for read data
    localparam logic [ST_W-1:0] ST_DONE = 2'd3;   // Completion cycle

endpackage

`default_nettype wire

/* source/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Memory access unit, core strobe in, L1 valid/ready port out

module lsu_top
    import lsu_pkg::*;
(
    input  logic              clk_i,
    input  logic              arst_n_i,

    input  logic              req_valid_i,
    input  logic [OP_W-1:0]   req_op_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [DATA_W-1:0] req_wdata_i,
    output logic              busy_o,
    output logic              done_o,
    output logic [DATA_W-1:0] rdata_o,
    output logic              misaligned_o,

    output logic              port_req_valid_o,
    output logic [ADDR_W-1:0] port_req_addr_o,
    output logic              port_req_write_o,
    output logic [DATA_W-1:0] port_req_wdata_o,
    output logic [STRB_W-1:0] port_req_strb_o,
    input  logic              port_req_ready_i,
    input  logic              port_rsp_valid_i,
    input  logic [DATA_W-1:0] port_rsp_data_i,
    output logic              port_rsp_ready_o
);

    logic [OP_W-1:0]   ctrl_op;
    logic [ADDR_W-1:0] ctrl_addr;
    logic [STRB_W-1:0] st_strb;
    logic [DATA_W-1:0] st_lane_data;
    logic              st_misaligned;
    logic [DATA_W-1:0] ld_value;

    data_bus_unit u_ctrl (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .req_valid_i      (req_valid_i),
        .req_op_i         (req_op_i),
        .req_addr_i       (req_addr_i),
        .req_wdata_i      (req_wdata_i),
        .strb_i           (st_strb),
        .lane_data_i      (st_lane_data),
        .misaligned_i     (st_misaligned),
        .value_i          (ld_value),
        .op_o             (ctrl_op),
        .addr_o           (ctrl_addr),
        .busy_o           (busy_o),
        .done_o           (done_o),
        .rdata_o          (rdata_o),
        .misaligned_o     (misaligned_o),
        .port_req_valid_o (port_req_valid_o),
        .port_req_addr_o  (port_req_addr_o),
        .port_req_write_o (port_req_write_o),
        .port_req_wdata_o (port_req_wdata_o),
        .port_req_strb_o  (port_req_strb_o),
        .port_req_ready_i (port_req_ready_i),
        .port_rsp_valid_i (port_rsp_valid_i),
        .port_rsp_data_i  (port_rsp_data_i),
        .port_rsp_ready_o (port_rsp_ready_o)
    );

    store_align u_store (
        .op_i         (ctrl_op),
        .addr_i       (ctrl_addr),
        .wdata_i      (req_wdata_i),   // Sampled on the accepting edge only
        .strb_o       (st_strb),
        .lane_data_o  (st_lane_data),
        .misaligned_o (st_misaligned)
    );

    load_extract u_load (
        .op_i     (ctrl_op),
        .offset_i (ctrl_addr[OFF_W-1:0]),
        .word_i   (port_rsp_data_i),
        .value_o  (ld_value)
    );

endmodule

`default_nettype wire

/* source/store_align.sv */
`timescale 1ns/1ps
`default_nettype none

// Store lane placement and alignment check for one access

module store_align
    import lsu_pkg::*;
(
    input  logic [OP_W-1:0]   op_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [STRB_W-1:0] strb_o,
    output logic [DATA_W-1:0] lane_data_o,
    output logic              misaligned_o
);

    logic [1:0]       size;
    logic [OFF_W-1:0] offset;

    assign size   = op_i[1:0];
    assign offset = addr_i[OFF_W-1:0];

    always_comb begin
        strb_o       = '0;
        lane_data_o  = wdata_i;
        misaligned_o = 1'b0;

        case (size)
            SIZE_B: begin
                // Byte copied to all four lanes, strobe picks one
                lane_data_o = {(DATA_W/8){wdata_i[7:0]}};
                strb_o      = 4'b0001 << offset;
            end
            SIZE_H: begin
                lane_data_o  = {(DATA_W/16){wdata_i[15:0]}};
                strb_o       = 4'b0011 << offset;
                misaligned_o = offset[0];             // Odd byte address
            end
            default: begin
                // Word, and the reserved size code behaves as a word
                lane_data_o  = wdata_i;
                strb_o       = '1;
                misaligned_o = (offset != '0);
            end
        endcase
    end

endmodule

`default_nettype wire
